// ==== hw/cpuPkg.sv ====
package cpuPkg;

    localparam int DataW = 8;
    localparam int AddrW = 8;
    localparam int InstrW = 16;
    localparam int RegSelW = 2;

    typedef logic [DataW-1:0] dataT;

    typedef enum logic [3:0] {
        OP_AND = 4'h0,
        OP_OR  = 4'h1,
        OP_NOT = 4'h2,
        OP_ADD = 4'h3,
        OP_SUB = 4'h4,
        OP_LSR = 4'h5,
        OP_LSL = 4'h6,
        OP_INC = 4'h7,
        OP_DEC = 4'h8,
        OP_MOV = 4'h9,
        OP_LD  = 4'hA,
        OP_ST  = 4'hB,
        OP_BRA = 4'hC,
        OP_BNE = 4'hD,
        OP_NOP = 4'hE,
        OP_HLT = 4'hF
    } opcodeT;

    typedef enum logic [1:0] {
        FUN_HOLD,
        FUN_LOAD,
        FUN_DEC,
        FUN_INC
    } regFunT;

    typedef enum logic [2:0] {
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_ADD,
        ALU_SUB,
        ALU_LSR,
        ALU_LSL,
        ALU_PASSA
    } aluOpT;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_HI,
        FETCH_LO,
        EXEC,
        MEMRD,
        HALT
    } cpuStateT;

    function automatic opcodeT getOp(input logic [InstrW-1:0] instr);
        return opcodeT'(instr[15:12]);
    endfunction

    function automatic logic [RegSelW-1:0] getDst(input logic [InstrW-1:0] instr);
        return instr[11:10];
    endfunction

    function automatic logic [RegSelW-1:0] getSrc1(input logic [InstrW-1:0] instr);
        return instr[9:8];
    endfunction

    function automatic logic [RegSelW-1:0] getSrc2(input logic [InstrW-1:0] instr);
        return instr[7:6];
    endfunction

    // LD only, 1 is immediate
    function automatic logic getMode(input logic [InstrW-1:0] instr);
        return instr[8];
    endfunction

    function automatic dataT getImm(input logic [InstrW-1:0] instr);
        return instr[7:0];
    endfunction

endpackage

// ==== hw/ctrlIf.sv ====
`timescale 1ns/100ps

interface ctrlIf;

    cpuPkg::regFunT rfFun;
    logic [cpuPkg::RegSelW-1:0] rfWrSel;
    logic [cpuPkg::RegSelW-1:0] rdSelA;
    logic [cpuPkg::RegSelW-1:0] rdSelB;
    cpuPkg::aluOpT aluOp;
    logic flagEn;
    cpuPkg::regFunT pcFun;
    logic irLoadHi;
    logic irLoadLo;
    logic memWr;
    logic addrFromIr;     // Address from IR low byte, else PC
    logic wrFromMem;
    logic immSel;

    // Status back to the control unit
    logic [cpuPkg::InstrW-1:0] instr;
    logic zeroFlag;

    modport ctrl (
        output rfFun, rfWrSel, rdSelA, rdSelB, aluOp, flagEn, pcFun,
        output irLoadHi, irLoadLo, memWr, addrFromIr, wrFromMem, immSel,
        input  instr, zeroFlag
    );

    modport dp (
        input  rfFun, rfWrSel, rdSelA, rdSelB, aluOp, flagEn, pcFun,
        input  irLoadHi, irLoadLo, memWr, addrFromIr, wrFromMem, immSel,
        output instr, zeroFlag
    );

endinterface

// ==== hw/countReg.sv ====
`timescale 1ns/100ps

module countReg #(
    parameter int Width = cpuPkg::DataW
) (
    input  logic             CLK,
    input  logic             arstN_i,
    input  cpuPkg::regFunT   fun_i,
    input  logic [Width-1:0] d_i,
    output logic [Width-1:0] q_o
);

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            q_o <= '0;
        end else begin
            case (fun_i)
                cpuPkg::FUN_LOAD: q_o <= d_i;
                cpuPkg::FUN_DEC:  q_o <= q_o - 1'b1;  // Wraps
                cpuPkg::FUN_INC:  q_o <= q_o + 1'b1;
                default:          q_o <= q_o;
            endcase
        end
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic                       CLK,
    input  logic                       arstN_i,
    input  cpuPkg::regFunT             fun_i,
    input  logic [cpuPkg::RegSelW-1:0] wrSel_i,
    input  cpuPkg::dataT               d_i,
    input  logic [cpuPkg::RegSelW-1:0] rdSelA_i,
    input  logic [cpuPkg::RegSelW-1:0] rdSelB_i,
    output cpuPkg::dataT               rdA_o,
    output cpuPkg::dataT               rdB_o
);

    localparam int NumRegs = 2 ** cpuPkg::RegSelW;

    cpuPkg::dataT regQ [NumRegs];

    for (genvar i = 0; i < NumRegs; i++) begin : g_reg
        localparam logic [cpuPkg::RegSelW-1:0] Sel = i;

        cpuPkg::regFunT fun;

        // Unselected registers hold
        assign fun = (wrSel_i == Sel) ? fun_i : cpuPkg::FUN_HOLD;

        countReg #(
            .Width(cpuPkg::DataW)
        ) i_countReg (
            .CLK    (CLK),
            .arstN_i(arstN_i),
            .fun_i  (fun),
            .d_i    (d_i),
            .q_o    (regQ[i])
        );
    end

    assign rdA_o = regQ[rdSelA_i];
    assign rdB_o = regQ[rdSelB_i];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic          CLK,
    input  logic          arstN_i,
    input  cpuPkg::aluOpT op_i,
    input  cpuPkg::dataT  a_i,
    input  cpuPkg::dataT  b_i,
    input  logic          flagEn_i,
    output cpuPkg::dataT  result_o,
    output logic          zero_o
);

    always_comb begin
        case (op_i)
            cpuPkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            cpuPkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            cpuPkg::ALU_NOT: begin
                result_o = ~a_i;
            end
            cpuPkg::ALU_ADD: begin
                result_o = a_i + b_i;   // Carry dropped
            end
            cpuPkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            cpuPkg::ALU_LSR: begin
                result_o = a_i >> 1;
            end
            cpuPkg::ALU_LSL: begin
                result_o = a_i << 1;
            end
            default: begin
                result_o = a_i;         // PASSA for MOV
            end
        endcase
    end

    // Z follows the last flag-updating instruction
    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            zero_o <= 1'b0;
        end else if (flagEn_i) begin
            zero_o <= (result_o == '0);
        end
    end

endmodule

// ==== hw/memory.sv ====
`timescale 1ns/100ps

module memory #(
    parameter int MemWords = 256
) (
    input  logic                     CLK,
    input  logic                     wrEn_i,
    input  logic [cpuPkg::AddrW-1:0] addr_i,
    input  cpuPkg::dataT             wrData_i,
    input  logic                     ldEn_i,
    input  logic [cpuPkg::AddrW-1:0] ldAddr_i,
    input  cpuPkg::dataT             ldData_i,
    output cpuPkg::dataT             rdData_o
);

    cpuPkg::dataT mem [MemWords];

    always_ff @(posedge CLK) begin
        if (ldEn_i) begin
            mem[ldAddr_i] <= ldData_i;  // Load port has priority
        end else if (wrEn_i) begin
            mem[addr_i] <= wrData_i;
        end
    end

    assign rdData_o = mem[addr_i];

endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
    input  logic    CLK,
    input  logic    arstN_i,
    input  logic    run_i,
    ctrlIf.ctrl     bus,
    output logic    halted_o
);

    cpuPkg::cpuStateT state;
    cpuPkg::cpuStateT stateNext;
    cpuPkg::opcodeT op;
    logic aluInstr;

    assign op = cpuPkg::getOp(bus.instr);

    assign aluInstr = op inside {cpuPkg::OP_AND, cpuPkg::OP_OR, cpuPkg::OP_NOT,
                                 cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_LSR,
                                 cpuPkg::OP_LSL, cpuPkg::OP_MOV};

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= cpuPkg::IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        case (state)
            cpuPkg::IDLE:     stateNext = run_i ? cpuPkg::FETCH_HI : cpuPkg::IDLE;
            cpuPkg::FETCH_HI: stateNext = cpuPkg::FETCH_LO;
            cpuPkg::FETCH_LO: stateNext = (op == cpuPkg::OP_HLT) ? cpuPkg::HALT : cpuPkg::EXEC;
            cpuPkg::EXEC: begin
                // Direct LD needs a second cycle for the data read
                if (op == cpuPkg::OP_LD && !cpuPkg::getMode(bus.instr)) begin
                    stateNext = cpuPkg::MEMRD;
                end else begin
                    stateNext = cpuPkg::FETCH_HI;
                end
            end
            cpuPkg::MEMRD:    stateNext = cpuPkg::FETCH_HI;
            cpuPkg::HALT:     stateNext = cpuPkg::HALT;
            default:          stateNext = cpuPkg::IDLE;
        endcase
    end

    always_comb begin
        bus.rfFun      = cpuPkg::FUN_HOLD;
        bus.rfWrSel    = cpuPkg::getDst(bus.instr);
        bus.rdSelA     = cpuPkg::getSrc1(bus.instr);
        bus.rdSelB     = (op == cpuPkg::OP_ST) ? cpuPkg::getDst(bus.instr)
                                               : cpuPkg::getSrc2(bus.instr);
        bus.aluOp      = cpuPkg::ALU_PASSA;
        bus.flagEn     = 1'b0;
        bus.pcFun      = cpuPkg::FUN_HOLD;
        bus.irLoadHi   = 1'b0;
        bus.irLoadLo   = 1'b0;
        bus.memWr      = 1'b0;
        bus.addrFromIr = 1'b0;
        bus.wrFromMem  = 1'b0;
        bus.immSel     = 1'b0;

        case (state)
            cpuPkg::FETCH_HI: begin
                bus.irLoadHi = 1'b1;
                bus.pcFun    = cpuPkg::FUN_INC;
            end
            cpuPkg::FETCH_LO: begin
                bus.irLoadLo = 1'b1;
                bus.pcFun    = cpuPkg::FUN_INC;
            end
            cpuPkg::EXEC: begin
                case (op)
                    cpuPkg::OP_AND: bus.aluOp = cpuPkg::ALU_AND;
                    cpuPkg::OP_OR:  bus.aluOp = cpuPkg::ALU_OR;
                    cpuPkg::OP_NOT: bus.aluOp = cpuPkg::ALU_NOT;
                    cpuPkg::OP_ADD: bus.aluOp = cpuPkg::ALU_ADD;
                    cpuPkg::OP_SUB: bus.aluOp = cpuPkg::ALU_SUB;
                    cpuPkg::OP_LSR: bus.aluOp = cpuPkg::ALU_LSR;
                    cpuPkg::OP_LSL: bus.aluOp = cpuPkg::ALU_LSL;
                    cpuPkg::OP_INC: bus.rfFun = cpuPkg::FUN_INC;   // In place, Z untouched
                    cpuPkg::OP_DEC: bus.rfFun = cpuPkg::FUN_DEC;
                    cpuPkg::OP_LD: begin
                        if (cpuPkg::getMode(bus.instr)) begin
                            bus.immSel = 1'b1;
                            bus.rfFun  = cpuPkg::FUN_LOAD;
                        end
                    end
                    cpuPkg::OP_ST: begin
                        bus.addrFromIr = 1'b1;
                        bus.memWr      = 1'b1;
                    end
                    cpuPkg::OP_BRA: bus.pcFun = cpuPkg::FUN_LOAD;
                    cpuPkg::OP_BNE: begin
                        if (!bus.zeroFlag) begin
                            bus.pcFun = cpuPkg::FUN_LOAD;
                        end
                    end
                    default: ;  // NOP, and MOV passes A as set above
                endcase
                if (aluInstr) begin
                    bus.rfFun  = cpuPkg::FUN_LOAD;
                    bus.flagEn = 1'b1;
                end
            end
            cpuPkg::MEMRD: begin
                bus.addrFromIr = 1'b1;
                bus.wrFromMem  = 1'b1;
                bus.rfFun      = cpuPkg::FUN_LOAD;
            end
            default: ;
        endcase
    end

    assign halted_o = (state == cpuPkg::HALT);

endmodule

// ==== hw/dataPath.sv ====
`timescale 1ns/100ps

module dataPath #(
    parameter int MemWords = 256
) (
    input  logic                     CLK,
    input  logic                     arstN_i,
    ctrlIf.dp                        bus,
    input  logic                     loadEn_i,
    input  logic [cpuPkg::AddrW-1:0] loadAddr_i,
    input  cpuPkg::dataT             loadData_i,
    output logic                     stValid_o,
    output logic [cpuPkg::AddrW-1:0] stAddr_o,
    output cpuPkg::dataT             stData_o
);

    logic [cpuPkg::InstrW/2-1:0] irHi;
    logic [cpuPkg::InstrW/2-1:0] irLo;
    logic [cpuPkg::AddrW-1:0] pc;
    logic [cpuPkg::AddrW-1:0] memAddr;
    cpuPkg::dataT memRd;
    cpuPkg::dataT rdA;
    cpuPkg::dataT rdB;
    cpuPkg::dataT aluRes;
    cpuPkg::dataT wrData;

    // IR filled one byte per fetch cycle
    always_ff @(posedge CLK) begin
        if (bus.irLoadHi) begin
            irHi <= memRd;
        end
        if (bus.irLoadLo) begin
            irLo <= memRd;
        end
    end

    assign bus.instr = {irHi, irLo};

    countReg #(
        .Width(cpuPkg::AddrW)
    ) i_pc (
        .CLK    (CLK),
        .arstN_i(arstN_i),
        .fun_i  (bus.pcFun),
        .d_i    (cpuPkg::getImm(bus.instr)),   // Branch target
        .q_o    (pc)
    );

    assign memAddr = bus.addrFromIr ? cpuPkg::getImm(bus.instr) : pc;

    always_comb begin
        if (bus.wrFromMem) begin
            wrData = memRd;
        end else if (bus.immSel) begin
            wrData = cpuPkg::getImm(bus.instr);
        end else begin
            wrData = aluRes;
        end
    end

    regFile i_regFile (
        .CLK     (CLK),
        .arstN_i (arstN_i),
        .fun_i   (bus.rfFun),
        .wrSel_i (bus.rfWrSel),
        .d_i     (wrData),
        .rdSelA_i(bus.rdSelA),
        .rdSelB_i(bus.rdSelB),
        .rdA_o   (rdA),
        .rdB_o   (rdB)
    );

    alu i_alu (
        .CLK     (CLK),
        .arstN_i (arstN_i),
        .op_i    (bus.aluOp),
        .a_i     (rdA),
        .b_i     (rdB),
        .flagEn_i(bus.flagEn),
        .result_o(aluRes),
        .zero_o  (bus.zeroFlag)
    );

    memory #(
        .MemWords(MemWords)
    ) i_memory (
        .CLK     (CLK),
        .wrEn_i  (bus.memWr),
        .addr_i  (memAddr),
        .wrData_i(rdB),
        .ldEn_i  (loadEn_i),
        .ldAddr_i(loadAddr_i),
        .ldData_i(loadData_i),
        .rdData_o(memRd)
    );

    // Store monitor mirrors the memory write port
    assign stValid_o = bus.memWr;
    assign stAddr_o  = memAddr;
    assign stData_o  = rdB;

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop #(
    parameter int MemWords = 256
) (
    input  logic                     CLK,
    input  logic                     arstN_i,
    input  logic                     run_i,
    input  logic                     loadEn_i,
    input  logic [cpuPkg::AddrW-1:0] loadAddr_i,
    input  cpuPkg::dataT             loadData_i,
    output logic                     halted_o,
    output logic                     stValid_o,
    output logic [cpuPkg::AddrW-1:0] stAddr_o,
    output cpuPkg::dataT             stData_o
);

    ctrlIf ctrlBus ();

    controlUnit i_controlUnit (
        .CLK     (CLK),
        .arstN_i (arstN_i),
        .run_i   (run_i),
        .bus     (ctrlBus.ctrl),
        .halted_o(halted_o)
    );

    dataPath #(
        .MemWords(MemWords)
    ) i_dataPath (
        .CLK       (CLK),
        .arstN_i   (arstN_i),
        .bus       (ctrlBus.dp),
        .loadEn_i  (loadEn_i),
        .loadAddr_i(loadAddr_i),
        .loadData_i(loadData_i),
        .stValid_o (stValid_o),
        .stAddr_o  (stAddr_o),
        .stData_o  (stData_o)
    );

endmodule

// ==== tb/cpuTop_props.sv ====
`timescale 1ns/100ps

module cpuTopProps (
    input logic CLK,
    input logic arstN_i,
    input logic halted_i,
    input logic stValid_i
);

    int assertFails = 0;

    // A store lasts one EXEC cycle
    stPulse: assert property (@(posedge CLK) disable iff (!arstN_i)
        stValid_i |=> !stValid_i)
        else begin
            assertFails++;
            $error("stValid_o stayed high for more than one cycle");
        end

    noStoreHalted: assert property (@(posedge CLK) disable iff (!arstN_i)
        !(stValid_i && halted_i))
        else begin
            assertFails++;
            $error("stValid_o high while halted_o is high");
        end

    haltSticky: assert property (@(posedge CLK) disable iff (!arstN_i)
        halted_i |=> halted_i)
        else begin
            assertFails++;
            $error("halted_o fell without a reset");
        end

endmodule

bind cpuTop cpuTopProps i_cpuTopProps (
    .CLK      (CLK),
    .arstN_i  (arstN_i),
    .halted_i (halted_o),
    .stValid_i(stValid_o)
);

// ==== tb/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb;

    localparam int NumRows = 13;
    localparam int MaxWords = 8;
    localparam int MaxSt = 4;
    localparam int RunTimeout = 200;    // Cycles allowed per program

    logic CLK;
    logic arstN_i;
    logic run_i;
    logic loadEn_i;
    logic [cpuPkg::AddrW-1:0] loadAddr_i;
    cpuPkg::dataT loadData_i;
    logic halted_o;
    logic stValid_o;
    logic [cpuPkg::AddrW-1:0] stAddr_o;
    cpuPkg::dataT stData_o;

    // Program table with one row per program
    logic [cpuPkg::InstrW-1:0] prog [NumRows][MaxWords];
    int nWords [NumRows];
    logic preValid [NumRows];
    logic [cpuPkg::AddrW-1:0] preAddr [NumRows];
    cpuPkg::dataT preData [NumRows];
    logic [cpuPkg::AddrW-1:0] expAddr [NumRows][MaxSt];
    cpuPkg::dataT expData [NumRows][MaxSt];
    int nExpSt [NumRows];
    int expCycles [NumRows];

    int mismatches;
    int failures;
    int curRow;
    logic [31:0] lcgState;

    cpuTop #(
        .MemWords(256)
    ) i_cpuTop (
        .CLK       (CLK),
        .arstN_i   (arstN_i),
        .run_i     (run_i),
        .loadEn_i  (loadEn_i),
        .loadAddr_i(loadAddr_i),
        .loadData_i(loadData_i),
        .halted_o  (halted_o),
        .stValid_o (stValid_o),
        .stAddr_o  (stAddr_o),
        .stData_o  (stData_o)
    );

    always #50 CLK = ~CLK;

    function automatic cpuPkg::dataT nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[23:16];
    endfunction

    function automatic logic [15:0] encAlu(cpuPkg::opcodeT op, logic [1:0] dst,
                                           logic [1:0] s1, logic [1:0] s2);
        return {op, dst, s1, s2, 6'b0};
    endfunction

    // Register, mode bit and byte field
    function automatic logic [15:0] encMem(cpuPkg::opcodeT op, logic [1:0] r,
                                           logic imm, cpuPkg::dataT val);
        return {op, r, 1'b0, imm, val};
    endfunction

    task automatic addWord(int row, logic [15:0] word);
        prog[row][nWords[row]] = word;
        nWords[row]++;
    endtask

    task automatic expectStore(int row, logic [7:0] addr, cpuPkg::dataT data);
        expAddr[row][nExpSt[row]] = addr;
        expData[row][nExpSt[row]] = data;
        nExpSt[row]++;
    endtask

    task automatic buildTable();
        cpuPkg::opcodeT aluOps [8];
        cpuPkg::dataT a;
        cpuPkg::dataT b;
        cpuPkg::dataT res;
        logic [15:0] hltW;
        aluOps = '{cpuPkg::OP_AND, cpuPkg::OP_OR, cpuPkg::OP_NOT, cpuPkg::OP_ADD,
                   cpuPkg::OP_SUB, cpuPkg::OP_LSR, cpuPkg::OP_LSL, cpuPkg::OP_MOV};
        hltW = encMem(cpuPkg::OP_HLT, 2'd0, 1'b0, 8'h00);
        for (int r = 0; r < NumRows; r++) begin
            nWords[r] = 0;
            nExpSt[r] = 0;
            preValid[r] = 1'b0;
        end
        // Rows 0 to 7 compute R2 = R0 op R1
        for (int r = 0; r < 8; r++) begin
            a = nextRand();
            b = nextRand();
            case (aluOps[r])
                cpuPkg::OP_AND: res = a & b;
                cpuPkg::OP_OR:  res = a | b;
                cpuPkg::OP_NOT: res = ~a;
                cpuPkg::OP_ADD: res = a + b;
                cpuPkg::OP_SUB: res = a - b;
                cpuPkg::OP_LSR: res = {1'b0, a[7:1]};
                cpuPkg::OP_LSL: res = {a[6:0], 1'b0};
                default:        res = a;
            endcase
            addWord(r, encMem(cpuPkg::OP_LD, 2'd0, 1'b1, a));
            addWord(r, encMem(cpuPkg::OP_LD, 2'd1, 1'b1, b));
            addWord(r, encAlu(aluOps[r], 2'd2, 2'd0, 2'd1));
            addWord(r, encMem(cpuPkg::OP_ST, 2'd2, 1'b0, 8'h90));
            addWord(r, hltW);
            expectStore(r, 8'h90, res);
            expCycles[r] = 4 * 3 + 2;
        end
        // INC and DEC wrapping both ways
        res = 8'hFF;
        addWord(8, encMem(cpuPkg::OP_LD, 2'd3, 1'b1, res));
        addWord(8, encAlu(cpuPkg::OP_INC, 2'd3, 2'd0, 2'd0));
        addWord(8, encMem(cpuPkg::OP_ST, 2'd3, 1'b0, 8'h91));
        addWord(8, encAlu(cpuPkg::OP_DEC, 2'd3, 2'd0, 2'd0));
        addWord(8, encAlu(cpuPkg::OP_DEC, 2'd3, 2'd0, 2'd0));
        addWord(8, encMem(cpuPkg::OP_ST, 2'd3, 1'b0, 8'h92));
        addWord(8, hltW);
        res = res + 8'd1;
        expectStore(8, 8'h91, res);
        res = res - 8'd2;
        expectStore(8, 8'h92, res);
        expCycles[8] = 6 * 3 + 2;
        // LD direct from preload then ST and read back
        a = nextRand();
        b = nextRand();
        preValid[9] = 1'b1;
        preAddr[9] = 8'hA0;
        preData[9] = a;
        addWord(9, encMem(cpuPkg::OP_LD, 2'd0, 1'b0, 8'hA0));
        addWord(9, encMem(cpuPkg::OP_ST, 2'd0, 1'b0, 8'h94));
        addWord(9, encMem(cpuPkg::OP_LD, 2'd1, 1'b1, b));
        addWord(9, encMem(cpuPkg::OP_ST, 2'd1, 1'b0, 8'hA1));
        addWord(9, encMem(cpuPkg::OP_LD, 2'd2, 1'b0, 8'hA1));
        addWord(9, encMem(cpuPkg::OP_ST, 2'd2, 1'b0, 8'h95));
        addWord(9, hltW);
        expectStore(9, 8'h94, a);
        expectStore(9, 8'hA1, b);
        expectStore(9, 8'h95, b);
        expCycles[9] = 4 * 3 + 2 * 4 + 2;
        // BRA over the first store with a NOP before it
        a = nextRand();
        addWord(10, encMem(cpuPkg::OP_LD, 2'd0, 1'b1, a));
        addWord(10, encMem(cpuPkg::OP_NOP, 2'd0, 1'b0, 8'h00));
        addWord(10, encMem(cpuPkg::OP_BRA, 2'd0, 1'b0, 8'h08));
        addWord(10, encMem(cpuPkg::OP_ST, 2'd0, 1'b0, 8'hB0));
        addWord(10, encMem(cpuPkg::OP_ST, 2'd0, 1'b0, 8'hB1));
        addWord(10, hltW);
        expectStore(10, 8'hB1, a);
        expCycles[10] = 4 * 3 + 2;
        // BNE taken for unequal and not taken for equal operands
        for (int r = 11; r < 13; r++) begin
            a = nextRand();
            b = (r == 11) ? (a ^ (nextRand() | 8'h01)) : a;
            addWord(r, encMem(cpuPkg::OP_LD, 2'd0, 1'b1, a));
            addWord(r, encMem(cpuPkg::OP_LD, 2'd1, 1'b1, b));
            addWord(r, encAlu(cpuPkg::OP_SUB, 2'd2, 2'd0, 2'd1));
            addWord(r, encMem(cpuPkg::OP_BNE, 2'd0, 1'b0, 8'h0A));
            addWord(r, encMem(cpuPkg::OP_ST, 2'd0, 1'b0, 8'hB2));
            addWord(r, encMem(cpuPkg::OP_ST, 2'd2, 1'b0, 8'hB3));
            addWord(r, hltW);
            if (a != b) begin
                expectStore(r, 8'hB3, a - b);
                expCycles[r] = 5 * 3 + 2;
            end else begin
                expectStore(r, 8'hB2, a);
                expectStore(r, 8'hB3, a - b);
                expCycles[r] = 6 * 3 + 2;
            end
        end
    endtask

    task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t row %0d: %s got 0x%0h expected 0x%0h",
                     $time, curRow, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic applyReset();
        arstN_i = 1'b0;
        run_i = 1'b0;
        loadEn_i = 1'b0;
        repeat (5) @(negedge CLK);
        checkVal("halted_o", halted_o, 0);
        checkVal("stValid_o", stValid_o, 0);
        arstN_i = 1'b1;
        @(negedge CLK);
        checkVal("halted_o", halted_o, 0);
    endtask

    task automatic loadRow(int row);
        for (int i = 0; i < 2 * nWords[row]; i++) begin
            loadEn_i = 1'b1;
            loadAddr_i = 8'(i);
            loadData_i = i[0] ? prog[row][i/2][7:0] : prog[row][i/2][15:8];  // High byte first
            @(negedge CLK);
            checkVal("stValid_o", stValid_o, 0);
        end
        if (preValid[row]) begin
            loadAddr_i = preAddr[row];
            loadData_i = preData[row];
            @(negedge CLK);
        end
        loadEn_i = 1'b0;
        // Core must stay idle until run_i
        repeat (2) begin
            @(negedge CLK);
            checkVal("stValid_o", stValid_o, 0);
            checkVal("halted_o", halted_o, 0);
        end
    endtask

    task automatic runRow(int row);
        int cyc;
        int nGot;
        logic done;
        logic [7:0] gotAddr [MaxSt];
        cpuPkg::dataT gotData [MaxSt];
        cyc = 0;
        nGot = 0;
        done = 1'b0;
        run_i = 1'b1;
        while (!done && cyc < RunTimeout) begin
            @(negedge CLK);
            if (halted_o === 1'b1) begin
                done = 1'b1;
            end else begin
                cyc++;  // Cycle 1 is the first FETCH_HI
                if (stValid_o === 1'b1) begin
                    if (nGot < MaxSt) begin
                        gotAddr[nGot] = stAddr_o;
                        gotData[nGot] = stData_o;
                    end
                    nGot++;
                end
            end
        end
        run_i = 1'b0;
        if (!done) begin
            $display("row %0d: halted_o did not rise within %0d cycles", row, RunTimeout);
            failures++;
        end else begin
            checkVal("cycles to halted_o", cyc, expCycles[row]);
            // HALT holds with no stores until the next reset
            repeat (3) begin
                @(negedge CLK);
                checkVal("halted_o", halted_o, 1);
                checkVal("stValid_o", stValid_o, 0);
            end
        end
        checkVal("store count", nGot, nExpSt[row]);
        for (int k = 0; k < nExpSt[row] && k < nGot; k++) begin
            checkVal("stAddr_o", gotAddr[k], expAddr[row][k]);
            checkVal("stData_o", gotData[k], expData[row][k]);
        end
    endtask

    initial begin
        CLK = 1'b0;
        arstN_i = 1'b0;
        run_i = 1'b0;
        loadEn_i = 1'b0;
        loadAddr_i = '0;
        loadData_i = '0;
        mismatches = 0;
        failures = 0;
        curRow = 0;
        lcgState = 32'd86;
        buildTable();
        for (int r = 0; r < NumRows; r++) begin
            curRow = r;
            applyReset();
            loadRow(r);
            runRow(r);
        end
        failures += i_cpuTop.i_cpuTopProps.assertFails;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/cpuPkg.sv
hw/ctrlIf.sv
hw/countReg.sv
hw/regFile.sv
hw/alu.sv
hw/memory.sv
hw/controlUnit.sv
hw/dataPath.sv
hw/cpuTop.sv
tb/cpuTop_props.sv
tb/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu8

sources:
  - hw/cpuPkg.sv
  - hw/ctrlIf.sv
  - hw/countReg.sv
  - hw/regFile.sv
  - hw/alu.sv
  - hw/memory.sv
  - hw/controlUnit.sv
  - hw/dataPath.sv
  - hw/cpuTop.sv
  - target: simulation
    files:
      - tb/cpuTop_props.sv
      - tb/cpuTb.sv
